/* bench/rvc_patterns.txt */
# Counts are decimal and all other values hex
# Program lines give address and word, trace lines give pc, rd and data, the last line is the halt pc
30
000 123450b7
004 ffb00113
008 00700193
00c 40218233
010 003122b3
014 00313333
018 40115393
01c 0020c433
020 00518013
024 003064b3
028 00419513
02c 003455b3
030 00919463
034 00918463
03c 00218463
040 00219463
048 0021c463
04c 00314463
054 00315463
058 0021d463
060 00316463
064 0021e463
06c 0021f463
070 00317463
078 0100066f
088 00001697
08c 02560767
0a0 40119793
100 00e687b3
104 00100073
30
000 01 12345000
004 02 fffffffb
008 03 00000007
00c 04 0000000c
010 05 00000001
014 06 00000000
018 07 fffffffd
01c 08 edcbaffb
020 00 00000000
024 09 00000007
028 0a 00000070
02c 0b 01db975f
030 00 00000000
034 00 00000000
03c 00 00000000
040 00 00000000
048 00 00000000
04c 00 00000000
054 00 00000000
058 00 00000000
060 00 00000000
064 00 00000000
06c 00 00000000
070 00 00000000
078 0c 0000007c
088 0d 00001088
08c 0e 00000090
0a0 00 00000000
100 0f 00001118
104 00 00000000
104

/* rvc.f */
+incdir+logic
logic/rvc_pkg.sv
logic/rvc_stage_if.sv
logic/rvc_fetch.sv
logic/rvc_decode.sv
logic/rvc_execute.sv
logic/rvc_top.sv
bench/rvc_sva.sv
bench/rvc_tb.sv

/* Makefile */
SIM        := verilator
TOP        := rvc_tb
FILELIST   := rvc.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/rvc_tb.sv */
// Testbench for the core with program load, random run gaps and retire trace compare
`default_nettype none
`include "rvc_params.svh"

module rvc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW             = $clog2(`RVC_IMEM_WORDS);
  localparam int RETIRE_TIMEOUT = 32;
  localparam int HALT_TIMEOUT   = 8;
  localparam int QUIET_CYCLES   = 20;

  logic                 clk;
  logic                 arst_n;
  logic                 run;
  logic                 imem_we;
  logic [AW-1:0]        imem_waddr;
  logic [31:0]          imem_wdata;
  logic [`RVC_XLEN-1:0] pc;
  logic                 retire_valid;
  logic [`RVC_XLEN-1:0] retire_pc;
  logic [4:0]           retire_rd;
  logic [`RVC_XLEN-1:0] retire_data;
  logic                 halted;

  logic [31:0] prog_addr[$];
  logic [31:0] prog_word[$];
  logic [31:0] exp_pc[$];
  logic [4:0]  exp_rd[$];
  logic [31:0] exp_data[$];
  logic [31:0] halt_pc;
  logic [15:0] lfsr_q = 16'd40199;

  int value_errs = 0;
  int timeouts   = 0;
  int other_errs = 0;

  rvc_top u_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .run          (run),
    .imem_we      (imem_we),
    .imem_waddr   (imem_waddr),
    .imem_wdata   (imem_wdata),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR stepped once per random bit
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 16'hB400;
    return out;
  endfunction

  // Skips comment and empty lines
  task automatic next_line(input int fd, output string line, output bit got);
    int code;
    got  = 1'b0;
    line = "";
    while (!got && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") got = 1'b1;
    end
  endtask

  task automatic load_patterns(output bit ok);
    int          fd;
    int          n_prog;
    int          n_trace;
    int          i;
    string       line;
    bit          got;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    ok = 1'b0;
    fd = $fopen("bench/rvc_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/rvc_patterns.txt");
      other_errs++;
      return;
    end
    next_line(fd, line, got);
    if (!got || $sscanf(line, "%d", n_prog) != 1) n_prog = -1;
    for (i = 0; i < n_prog; i++) begin
      next_line(fd, line, got);
      if (!got || $sscanf(line, "%h %h", a, b) != 2) break;
      if (a[1:0] != 2'b00 || a >= `RVC_IMEM_WORDS * 4) begin
        $display("Program address %08h lies outside instruction memory", a);
        break;
      end
      prog_addr.push_back(a);
      prog_word.push_back(b);
    end
    next_line(fd, line, got);
    if (!got || $sscanf(line, "%d", n_trace) != 1) n_trace = -1;
    for (i = 0; i < n_trace; i++) begin
      next_line(fd, line, got);
      if (!got || $sscanf(line, "%h %h %h", a, b, c) != 3) break;
      exp_pc.push_back(a);
      exp_rd.push_back(b[4:0]);
      exp_data.push_back(c);
    end
    next_line(fd, line, got);
    if (got) got = $sscanf(line, "%h", halt_pc) == 1;
    ok = got && n_prog > 0 && prog_addr.size() == n_prog &&
         n_trace > 0 && exp_pc.size() == n_trace;
    if (!ok) begin
      $display("Pattern file is malformed or incomplete");
      other_errs++;
    end
    $fclose(fd);
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    if (pc !== `RVC_RESET_PC) begin
      $display("[ERROR] pc got %08h expected %08h after reset", pc, `RVC_RESET_PC);
      value_errs++;
    end
    if (retire_valid !== 1'b0) begin
      $display("[ERROR] retire_valid got %0h expected 0 after reset", retire_valid);
      value_errs++;
    end
    if (halted !== 1'b0) begin
      $display("[ERROR] halted got %0h expected 0 after reset", halted);
      value_errs++;
    end
  endtask

  // Program goes in while run is low
  task automatic load_program();
    int i;
    for (i = 0; i < prog_addr.size(); i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_waddr <= prog_addr[i][AW+1:2];
      imem_wdata <= prog_word[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task automatic check_retire(input int idx);
    if (retire_pc !== exp_pc[idx]) begin
      $display("[ERROR] retire_pc got %08h expected %08h at retirement %0d",
               retire_pc, exp_pc[idx], idx);
      value_errs++;
    end
    if (retire_rd !== exp_rd[idx]) begin
      $display("[ERROR] retire_rd got %02h expected %02h at retirement %0d",
               retire_rd, exp_rd[idx], idx);
      value_errs++;
    end
    if (retire_data !== exp_data[idx]) begin
      $display("[ERROR] retire_data got %08h expected %08h at retirement %0d",
               retire_data, exp_data[idx], idx);
      value_errs++;
    end
  endtask

  task automatic run_trace();
    int idx;
    int cyc;
    int last_cyc;
    int gap;
    int low_left;
    int waited;
    bit seen;
    idx      = 0;
    cyc      = 0;
    last_cyc = 0;
    gap      = 0;
    low_left = 0;
    while (idx < exp_pc.size()) begin
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < RETIRE_TIMEOUT) begin
        @(posedge clk);
        cyc++;
        if (low_left > 0) begin
          run <= 1'b0;
          low_left--;
        end else begin
          run <= 1'b1;
        end
        @(negedge clk);
        seen = retire_valid === 1'b1;
        waited++;
      end
      if (!seen) begin
        $display("Timeout waiting %0d cycles for retirement %0d", RETIRE_TIMEOUT, idx);
        timeouts++;
        return;
      end
      check_retire(idx);
      // Four cycles per instruction plus every cycle spent with run low
      if (idx > 0 && cyc - last_cyc != 4 + gap) begin
        $display("Retirement %0d came %0d cycles after the previous one instead of %0d",
                 idx, cyc - last_cyc, 4 + gap);
        other_errs++;
      end
      last_cyc = cyc;
      gap      = 0;
      if (lfsr_bit()) begin
        gap = 1;
        if (lfsr_bit()) gap = gap + 1;
        if (lfsr_bit()) gap = gap + 1;
      end
      low_left = gap;
      idx++;
    end
  endtask

  task automatic check_halt();
    int i;
    i = 0;
    while (halted !== 1'b1 && i < HALT_TIMEOUT) begin
      @(negedge clk);
      i++;
    end
    if (halted !== 1'b1) begin
      $display("Timeout waiting for halted after the last retirement");
      timeouts++;
      return;
    end
    for (i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (retire_valid !== 1'b0) begin
        $display("Unexpected retirement at pc %08h after halt", retire_pc);
        other_errs++;
      end
    end
    if (pc !== halt_pc) begin
      $display("[ERROR] pc got %08h expected %08h after halt", pc, halt_pc);
      value_errs++;
    end
  endtask

  initial begin
    bit ok;
    arst_n     <= 1'b0;
    run        <= 1'b0;
    imem_we    <= 1'b0;
    imem_waddr <= '0;
    imem_wdata <= '0;
    load_patterns(ok);
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    if (ok) begin
      check_reset_state();
      load_program();
      run_trace();
      if (timeouts == 0) check_halt();
    end
    $display("Summary: %0d value errors, %0d timeouts, %0d other errors",
             value_errs, timeouts, other_errs);
    if (value_errs + timeouts + other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/rvc_sva.sv */
// Bound protocol assertions for retire strobe, halt level and PC updates on the core top
`default_nettype none
`include "rvc_params.svh"

module rvc_sva (
  input logic                 clk,
  input logic                 arst_n,
  input logic [`RVC_XLEN-1:0] pc,
  input logic                 retire_valid,
  input logic                 halted
);
  timeunit 1ns;
  timeprecision 100ps;

  retire_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |=> !retire_valid)
    else $error("retire_valid stayed high for more than one cycle");

  no_retire_halted: assert property (@(posedge clk) disable iff (!arst_n)
    halted |-> !retire_valid)
    else $error("retire_valid fired while halted");

  // Only reset clears the halt level
  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> halted)
    else $error("halted fell without a reset");

  pc_after_retire: assert property (@(posedge clk) disable iff (!arst_n)
    $changed(pc) |-> $past(retire_valid))
    else $error("pc changed without a retirement in the cycle before");

endmodule

bind rvc_top rvc_sva u_sva (
  .clk          (clk),
  .arst_n       (arst_n),
  .pc           (pc),
  .retire_valid (retire_valid),
  .halted       (halted)
);

`default_nettype wire

/* logic/rvc_top.sv */
// Core top level connecting fetch, decode and execute
`default_nettype none
`include "rvc_params.svh"

module rvc_top (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               run,
  input  logic                               imem_we,
  input  logic [$clog2(`RVC_IMEM_WORDS)-1:0] imem_waddr,
  input  logic [31:0]                        imem_wdata,
  output logic [`RVC_XLEN-1:0]               pc,
  output logic                               retire_valid,
  output logic [`RVC_XLEN-1:0]               retire_pc,
  output logic [4:0]                         retire_rd,
  output logic [`RVC_XLEN-1:0]               retire_data,
  output logic                               halted
);

  logic        if_valid;
  logic [31:0] if_inst;

  dec_exe_if  u_dx ();
  redirect_if u_redir ();

  // Current PC doubles as the fetch PC handed to decode
  rvc_fetch u_fetch (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .halted     (halted),
    .imem_we    (imem_we),
    .imem_waddr (imem_waddr),
    .imem_wdata (imem_wdata),
    .redir      (u_redir.dst),
    .if_valid   (if_valid),
    .if_pc      (pc),
    .if_inst    (if_inst)
  );

  rvc_decode u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .if_valid (if_valid),
    .if_pc    (pc),
    .if_inst  (if_inst),
    .dx       (u_dx.src)
  );

  rvc_execute u_execute (
    .clk          (clk),
    .arst_n       (arst_n),
    .dx           (u_dx.dst),
    .redir        (u_redir.src),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

endmodule

`default_nettype wire

/* logic/rvc_execute.sv */
// Execute stage with register file, ALU, branch resolution, writeback, retire report and halt
`default_nettype none
`include "rvc_params.svh"

module rvc_execute (
  input  logic                 clk,
  input  logic                 arst_n,
  dec_exe_if.dst               dx,
  redirect_if.src              redir,
  output logic                 retire_valid,
  output logic [`RVC_XLEN-1:0] retire_pc,
  output logic [4:0]           retire_rd,
  output logic [`RVC_XLEN-1:0] retire_data,
  output logic                 halted
);

  logic [`RVC_XLEN-1:0] regs [32];
  logic [`RVC_XLEN-1:0] rs1_val;
  logic [`RVC_XLEN-1:0] rs2_val;
  logic [`RVC_XLEN-1:0] op_b;
  logic [`RVC_XLEN-1:0] alu_res;
  logic [`RVC_XLEN-1:0] result;
  logic [`RVC_XLEN-1:0] link;
  logic                 taken;
  logic                 wen;
  logic                 wr_en;
  logic                 is_halt;
  logic                 halt_pend;
  rvc_pkg::pc_sel_e     sel;

  // x0 is hardwired to zero on read
  assign rs1_val = dx.rs1 == 5'd0 ? '0 : regs[dx.rs1];
  assign rs2_val = dx.rs2 == 5'd0 ? '0 : regs[dx.rs2];
  assign op_b    = dx.cls == rvc_pkg::cls_alu_reg ? rs2_val : dx.imm;
  assign link    = dx.pc + `RVC_PC_STEP;

  always_comb begin
    case (dx.alu_op)
      rvc_pkg::alu_sub:  alu_res = rs1_val - op_b;
      rvc_pkg::alu_and:  alu_res = rs1_val & op_b;
      rvc_pkg::alu_or:   alu_res = rs1_val | op_b;
      rvc_pkg::alu_xor:  alu_res = rs1_val ^ op_b;
      rvc_pkg::alu_slt:  alu_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
      rvc_pkg::alu_sltu: alu_res = {31'b0, rs1_val < op_b};
      rvc_pkg::alu_sll:  alu_res = rs1_val << op_b[4:0];
      rvc_pkg::alu_srl:  alu_res = rs1_val >> op_b[4:0];
      rvc_pkg::alu_sra:  alu_res = $signed(rs1_val) >>> op_b[4:0];
      default:           alu_res = rs1_val + op_b;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (dx.funct3)
      3'b000:  taken = rs1_val == rs2_val;
      3'b001:  taken = rs1_val != rs2_val;
      3'b100:  taken = $signed(rs1_val) < $signed(rs2_val);
      3'b101:  taken = $signed(rs1_val) >= $signed(rs2_val);
      3'b110:  taken = rs1_val < rs2_val;
      3'b111:  taken = rs1_val >= rs2_val;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    result  = alu_res;
    wen     = 1'b1;
    sel     = rvc_pkg::pc_seq;
    is_halt = 1'b0;
    case (dx.cls)
      rvc_pkg::cls_alu_reg, rvc_pkg::cls_alu_imm: result = alu_res;
      rvc_pkg::cls_lui:   result = dx.imm;
      rvc_pkg::cls_auipc: result = dx.pc + dx.imm;
      rvc_pkg::cls_jal: begin
        result = link;
        sel    = rvc_pkg::pc_jal;
      end
      rvc_pkg::cls_jalr: begin
        result = link;
        sel    = rvc_pkg::pc_jalr;
      end
      rvc_pkg::cls_branch: begin
        wen = 1'b0;
        sel = taken ? rvc_pkg::pc_branch : rvc_pkg::pc_seq;
      end
      rvc_pkg::cls_ebreak: begin
        wen     = 1'b0;
        is_halt = 1'b1;
      end
      default: begin
        wen = 1'b0;
        sel = rvc_pkg::pc_trap;
      end
    endcase
  end

  assign wr_en = wen && dx.rd != 5'd0;

  always_ff @(posedge clk) begin
    if (dx.valid && wr_en) regs[dx.rd] <= result;
  end

  // ebreak leaves the PC on its own address and sets halted after it retires
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
      redir.pc_wen <= 1'b0;
      halt_pend    <= 1'b0;
      halted       <= 1'b0;
    end else begin
      retire_valid <= dx.valid;
      redir.pc_wen <= dx.valid && !is_halt;
      halt_pend    <= dx.valid && is_halt;
      if (halt_pend) halted <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dx.valid) begin
      retire_pc             <= dx.pc;
      retire_rd             <= wr_en ? dx.rd : 5'd0;
      retire_data           <= wr_en ? result : '0;
      redir.pc_sel          <= sel;
      redir.jump_reg_target <= (rs1_val + dx.imm) & ~`RVC_XLEN'd1;
      redir.br_target       <= dx.pc + dx.imm;
      redir.jmp_target      <= dx.pc + dx.imm;
    end
  end

endmodule

`default_nettype wire

/* logic/rvc_decode.sv */
// Decode stage with instruction register, format split, immediates and classification
`default_nettype none
`include "rvc_params.svh"

module rvc_decode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 if_valid,
  input  logic [`RVC_XLEN-1:0] if_pc,
  input  logic [31:0]          if_inst,
  dec_exe_if.src               dx
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  rvc_pkg::inst_u       inst_q;
  logic [`RVC_XLEN-1:0] pc_q;
  logic                 valid_q;
  logic [6:0]           opcode;
  logic [6:0]           funct7;
  logic [2:0]           funct3;
  logic                 f7_ok;

  function automatic rvc_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    rvc_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rvc_pkg::alu_sub : rvc_pkg::alu_add;
      3'b001:  op = rvc_pkg::alu_sll;
      3'b010:  op = rvc_pkg::alu_slt;
      3'b011:  op = rvc_pkg::alu_sltu;
      3'b100:  op = rvc_pkg::alu_xor;
      3'b101:  op = alt ? rvc_pkg::alu_sra : rvc_pkg::alu_srl;
      3'b110:  op = rvc_pkg::alu_or;
      default: op = rvc_pkg::alu_and;
    endcase
    return op;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) valid_q <= 1'b0;
    else valid_q <= if_valid;
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      inst_q <= if_inst;
      pc_q   <= if_pc;
    end
  end

  assign opcode = inst_q.r_fmt.opcode;
  assign funct7 = inst_q.r_fmt.funct7;
  assign funct3 = inst_q.r_fmt.funct3;
  // Alternate funct7 only valid on add/sub and the right shifts
  assign f7_ok    = funct7 == 7'b0 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    dx.cls    = rvc_pkg::cls_illegal;
    dx.alu_op = rvc_pkg::alu_add;
    dx.imm    = {{20{inst_q.i_fmt.imm_11_0[11]}}, inst_q.i_fmt.imm_11_0};
    case (opcode)
      OPC_OP: begin
        if (f7_ok) dx.cls = rvc_pkg::cls_alu_reg;
        dx.alu_op = alu_decode(funct3, funct7[5]);
      end
      OPC_OP_IMM: begin
        // Only the shift forms look at the funct7 bits
        if (!(funct3 == 3'b001 || funct3 == 3'b101) || f7_ok) dx.cls = rvc_pkg::cls_alu_imm;
        dx.alu_op = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);
      end
      OPC_LUI, OPC_AUIPC: begin
        dx.cls = opcode == OPC_LUI ? rvc_pkg::cls_lui : rvc_pkg::cls_auipc;
        dx.imm = {inst_q.u_fmt.imm_31_12, 12'b0};
      end
      OPC_JAL: begin
        dx.cls = rvc_pkg::cls_jal;
        dx.imm = {{11{inst_q.j_fmt.imm_20}}, inst_q.j_fmt.imm_20, inst_q.j_fmt.imm_19_12,
                  inst_q.j_fmt.imm_11, inst_q.j_fmt.imm_10_1, 1'b0};
      end
      OPC_JALR: if (funct3 == 3'b000) dx.cls = rvc_pkg::cls_jalr;
      OPC_BRANCH: begin
        if (funct3 != 3'b010 && funct3 != 3'b011) dx.cls = rvc_pkg::cls_branch;
        dx.imm = {{19{inst_q.b_fmt.imm_12}}, inst_q.b_fmt.imm_12, inst_q.b_fmt.imm_11,
                  inst_q.b_fmt.imm_10_5, inst_q.b_fmt.imm_4_1, 1'b0};
      end
      default: if (inst_q == 32'h0010_0073) dx.cls = rvc_pkg::cls_ebreak;
    endcase
  end

  assign dx.valid  = valid_q;
  assign dx.pc     = pc_q;
  assign dx.rd     = inst_q.r_fmt.rd;
  assign dx.rs1    = inst_q.r_fmt.rs1;
  assign dx.rs2    = inst_q.s_fmt.rs2;
  assign dx.funct3 = funct3;

endmodule

`default_nettype wire

/* logic/rvc_fetch.sv */
// Fetch stage with PC register, next-PC mux, instruction memory and issue control
`default_nettype none
`include "rvc_params.svh"

module rvc_fetch (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 run,
  input  logic                                 halted,
  input  logic                                 imem_we,
  input  logic [$clog2(`RVC_IMEM_WORDS)-1:0]   imem_waddr,
  input  logic [31:0]                          imem_wdata,
  redirect_if.dst                              redir,
  output logic                                 if_valid,
  output logic [`RVC_XLEN-1:0]                 if_pc,
  output logic [31:0]                          if_inst
);

  localparam int AW = $clog2(`RVC_IMEM_WORDS);

  logic [`RVC_XLEN-1:0] pc_q;
  logic [`RVC_XLEN-1:0] pc_next;
  logic                 busy;
  logic                 issue;
  logic [31:0]          mem [`RVC_IMEM_WORDS];

  // One instruction in flight until the writeback pulse
  assign issue = !busy && run && !halted;

  always_comb begin
    case (redir.pc_sel)
      rvc_pkg::pc_jalr:   pc_next = redir.jump_reg_target;
      rvc_pkg::pc_branch: pc_next = redir.br_target;
      rvc_pkg::pc_jal:    pc_next = redir.jmp_target;
      rvc_pkg::pc_trap:   pc_next = `RVC_TRAP_VEC;
      default:            pc_next = pc_q + `RVC_PC_STEP;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q     <= `RVC_RESET_PC;
      busy     <= 1'b0;
      if_valid <= 1'b0;
    end else begin
      if_valid <= issue;
      if (redir.pc_wen) pc_q <= pc_next;
      if (issue) busy <= 1'b1;
      else if (redir.pc_wen) busy <= 1'b0;
    end
  end

  // Load port and synchronous read at the PC word index
  always_ff @(posedge clk) begin
    if (imem_we) mem[imem_waddr] <= imem_wdata;
    if (issue) if_inst <= mem[pc_q[AW+1:2]];
  end

  assign if_pc = pc_q;

endmodule

`default_nettype wire

/* logic/rvc_stage_if.sv */
// Decode-to-execute bundle and execute-to-fetch redirect bundle
`default_nettype none
`include "rvc_params.svh"

interface dec_exe_if;
  logic                 valid;
  logic [`RVC_XLEN-1:0] pc;
  rvc_pkg::op_class_e   cls;
  rvc_pkg::alu_op_e     alu_op;
  logic [4:0]           rd;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [2:0]           funct3;
  logic [`RVC_XLEN-1:0] imm;

  modport src (output valid, pc, cls, alu_op, rd, rs1, rs2, funct3, imm);
  modport dst (input valid, pc, cls, alu_op, rd, rs1, rs2, funct3, imm);
endinterface

interface redirect_if;
  logic                 pc_wen;
  rvc_pkg::pc_sel_e     pc_sel;
  logic [`RVC_XLEN-1:0] jump_reg_target;
  logic [`RVC_XLEN-1:0] br_target;
  logic [`RVC_XLEN-1:0] jmp_target;

  modport src (output pc_wen, pc_sel, jump_reg_target, br_target, jmp_target);
  modport dst (input pc_wen, pc_sel, jump_reg_target, br_target, jmp_target);
endinterface

`default_nettype wire

/* logic/rvc_pkg.sv */
// Instruction format union, next-PC source, operation class and ALU operation types
`default_nettype none

package rvc_pkg;

  // One instruction word seen through each RISC-V base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_u;

  // Next-PC sources in the encoding of the fetch mux
  typedef enum logic [2:0] {
    pc_seq    = 3'b000,
    pc_jalr   = 3'b001,
    pc_branch = 3'b010,
    pc_jal    = 3'b011,
    pc_trap   = 3'b100
  } pc_sel_e;

  typedef enum logic [3:0] {
    cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc, cls_jal,
    cls_jalr, cls_branch, cls_ebreak, cls_illegal
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
  } alu_op_e;

endpackage

`default_nettype wire

/* logic/rvc_params.svh */
// Core widths, reset PC, PC step, trap vector and instruction memory depth
`ifndef RVC_PARAMS_SVH
`define RVC_PARAMS_SVH

// Data and address width
`define RVC_XLEN 32

// PC loaded on reset
`define RVC_RESET_PC 32'h0000_0000

// Sequential PC increment in bytes
`define RVC_PC_STEP 32'd4

// Target for illegal instructions inside instruction memory
`define RVC_TRAP_VEC 32'h0000_0100

// Instruction memory depth in 32-bit words
`define RVC_IMEM_WORDS 128

`endif
